//--- mul_core.f
src/ucode_pkg.sv
src/mul_decode.sv
src/ucode_sequencer.sv
src/issue_stage.sv
src/exec_stage.sv
src/mul_core_top.sv
sim/mul_core_properties.sv
sim/mul_core_tb.sv

//--- Bender.yml
package:
  name: mul_core

sources:
  - src/ucode_pkg.sv
  - src/mul_decode.sv
  - src/ucode_sequencer.sv
  - src/issue_stage.sv
  - src/exec_stage.sv
  - src/mul_core_top.sv
  - target: simulation
    files:
      - sim/mul_core_properties.sv
      - sim/mul_core_tb.sv

//--- sim/mul_core_tb.sv
// Testbench for the microcoded multiply pipeline, random programs checked against a model
`timescale 1ns/1ps

module mul_core_tb
    import ucode_pkg::*;
();

    localparam int NUM_TESTS      = 48;                       // Random MUL rounds
    localparam int TIMEOUT_CYCLES = 60 * (NUM_TESTS + 4);     // Directed part counts as 4

    logic              clk = 1'b0;
    logic              rst;
    logic              instr_valid;
    instr_t            instr;
    logic              busy;
    logic [REG_AW-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    flags_t            flags;

    logic [DATA_W-1:0] regs_m [NUM_REGS];   // Architectural register model
    flags_t            flags_m;             // Model NZCV
    int                seed        = 13710;
    int                cycle_count = 0;

    mul_core_top mul_core_top_inst (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .busy       (busy),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .flags      (flags)
    );

    always #4 clk = ~clk;   // 8 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "Timeout");
        end
    end

    // Bound sequencer assertions feed the verdict
    always @(negedge clk) begin
        if (mul_core_top_inst.ucode_sequencer_inst.seq_props.fail_count != 0) begin
            $display("A sequencer control assertion failed, see the error above");
            $display("tests failed");
            $fatal(1, "Sequencer assertion failure");
        end
    end

    function automatic int rand_range(int lo, int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    // Random register index different from a and b
    function automatic int pick_other(int a, int b);
        int r;
        r = rand_range(0, 15);
        while (r == a || r == b) begin
            r = rand_range(0, 15);
        end
        return r;
    endfunction

    function automatic instr_t reg_form_instr(logic [6:0] opc, int rd, int rs1, int rs2);
        instr_t i;
        i          = '0;
        i.opcode   = opc;
        i.rd       = REG_AW'(rd);
        i.rs1      = REG_AW'(rs1);
        i.op.r.rs2 = REG_AW'(rs2);
        return i;
    endfunction

    function automatic instr_t imm_form_instr(logic [6:0] opc, int rd, int rs1, logic [15:0] imm);
        instr_t i;
        i            = '0;
        i.opcode     = opc;
        i.rd         = REG_AW'(rd);
        i.rs1        = REG_AW'(rs1);
        i.op.i.imm16 = imm;
        return i;
    endfunction

    // One-cycle strobe, returns right after the edge that samples it
    task automatic strobe_instr(input instr_t i);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= i;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic check_reg(input int r);
        logic [DATA_W-1:0] got;
        @(posedge clk);
        rd_addr <= REG_AW'(r);
        @(negedge clk);
        got = rd_data;
        assert (got === regs_m[r]) else begin
            $display("CHECK FAILED at %0t ns: r%0d reads %h, expected %h",
                     $time, r, got, regs_m[r]);
            $display("tests failed");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic check_flags();
        @(negedge clk);
        assert (flags === flags_m) else begin
            $display("CHECK FAILED at %0t ns: NZCV is %b, expected %b", $time, flags, flags_m);
            $display("tests failed");
            $fatal(1, "Flag mismatch");
        end
    endtask

    // MOV, sign extended imm16, flags untouched
    task automatic load_reg(input int r, input logic [15:0] imm);
        strobe_instr(imm_form_instr(MOV_OP, r, 0, imm));
        regs_m[r] = {{16{imm[15]}}, imm};
        repeat (2) @(posedge clk);      // Issue then exec write
        check_reg(r);
        check_flags();
    endtask

    // ADD, ADDS or SUBS issued directly
    task automatic alu_op(input logic [6:0] opc, input int rd, input int rs1, input int rs2);
        logic [DATA_W-1:0] a, b, r;
        logic              carry;
        longint            exact;       // Signed result before wrapping to 32 bits
        a = regs_m[rs1];
        b = regs_m[rs2];
        strobe_instr(reg_form_instr(opc, rd, rs1, rs2));
        if (opc == ADD_OP || opc == ADDS_OP) begin
            {carry, r} = {1'b0, a} + {1'b0, b};
        end else begin
            r     = a - b;
            carry = (a >= b);           // No borrow
        end
        regs_m[rd] = r;
        if (opc == ADDS_OP || opc == SUBS_OP) begin
            flags_m.n = r[DATA_W-1];
            flags_m.z = (r == '0);
            flags_m.c = carry;
            exact = (opc == ADDS_OP) ? longint'($signed(a)) + longint'($signed(b))
                                     : longint'($signed(a)) - longint'($signed(b));
            // Overflow when the true signed result does not fit
            flags_m.v = (exact != longint'($signed(r)));
        end
        repeat (2) @(posedge clk);
    endtask

    // Strobe a MUL, optionally poke a second MUL under busy, wait for the end
    task automatic run_mul(input instr_t i, input bit poke);
        strobe_instr(i);
        @(negedge clk);
        assert (busy) else begin
            $display("CHECK FAILED at %0t ns: busy still low after a MUL was accepted", $time);
            $display("tests failed");
            $fatal(1, "Busy missing");
        end
        if (poke) begin
            strobe_instr(imm_form_instr(MUL_BASE_OP, i.rs1, i.rs1, 16'h0003));  // Must be dropped
            @(negedge clk);
        end
        while (busy) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic multiply(input mul_kind_t kind, input int rd, input int rs, input int rm,
                            input logic [15:0] imm, input bit poke);
        instr_t            mi;
        logic [DATA_W-1:0] mval;        // Multiplier as the kind defines it
        logic [6:0]        opc;
        opc = MUL_BASE_OP | 7'(kind);
        if (kind == MULR || kind == MULSR) begin
            mi   = reg_form_instr(opc, rd, rs, rm);
            mval = regs_m[rm];
        end else begin
            mi   = imm_form_instr(opc, rd, rs, imm);
            mval = (kind == MULSI) ? {{16{imm[15]}}, imm} : {16'h0, imm};
        end
        run_mul(mi, poke);
        regs_m[rd] = regs_m[rs] * mval;     // Low 32 bits, flags kept
        check_reg(rd);
        check_reg(rs);
        check_flags();
    endtask

    initial begin : main
        int kind, rd, rs, rm, src, mult;
        logic [6:0] opc;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rd_addr     = '0;
        flags_m     = '0;
        for (int k = 0; k < NUM_REGS; k++) begin
            regs_m[k] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Directed overflow, 2^14 doubled up to 2^30
        load_reg(1, 16'h4000);
        for (int k = 0; k < 16; k++) begin
            alu_op(ADD_OP, 1, 1, 1);
        end
        check_reg(1);
        load_reg(4, 16'h0001);
        alu_op(ADDS_OP, 2, 1, 1);       // 2^31, N and V
        check_reg(2);
        check_flags();
        alu_op(SUBS_OP, 3, 2, 4);       // Wraps positive, C and V
        check_reg(3);
        check_flags();
        multiply(MULSI, 6, 4, 0, 16'hfffd, 1'b1);

        // Random rounds
        for (int t = 0; t < NUM_TESTS; t++) begin
            kind = rand_range(0, 3);
            rd   = rand_range(0, 15);
            rs   = pick_other(rd, rd);
            rm   = pick_other(rd, rs);
            src  = rand_range(-20, 20);
            mult = kind[1] ? rand_range(-20, 20) : rand_range(0, 20);
            if (t % 8 == 3) begin
                mult = 0;
            end
            load_reg(rs, 16'(src));
            load_reg(rm, 16'(mult));
            opc = rand_range(0, 1) ? ADDS_OP : SUBS_OP;
            alu_op(opc, rd, rs, rm);    // Fresh flags before the MUL
            check_reg(rd);
            check_flags();
            multiply(mul_kind_t'(kind), rd, rs, rm, 16'(mult), (t % 5 == 2));
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim/mul_core_properties.sv
// Sequencer control checks, bound into the microcode sequencer
`timescale 1ns/1ps

module mul_core_properties (
    input logic clk,
    input logic rst,
    input logic start_mul,
    input logic busy,
    input logic uop_active,
    input logic flags_restore,
    input logic idle            // FSM in its idle state
);

    int fail_count = 0;         // Read by the testbench monitor

    // Restore only in the last busy cycle
    restore_ends_busy: assert property (@(posedge clk) disable iff (rst)
        flags_restore |-> busy ##1 !busy)
        else begin
            fail_count++;
            $error("flags_restore outside the last busy cycle");
        end

    // Slot stays free through reset
    no_uop_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !uop_active)
        else begin
            fail_count++;
            $error("uop_active high during reset");
        end

    no_uop_in_idle: assert property (@(posedge clk) disable iff (rst)
        idle |-> !uop_active)
        else begin
            fail_count++;
            $error("uop_active high while the sequencer is idle");
        end

    // New MUL only reaches an idle sequencer
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start_mul |-> idle)
        else begin
            fail_count++;
            $error("start_mul while the sequencer is busy");
        end

endmodule

bind ucode_sequencer mul_core_properties seq_props (
    .clk          (clk),
    .rst          (rst),
    .start_mul    (start_mul),
    .busy         (busy),
    .uop_active   (uop_active),
    .flags_restore(flags_restore),
    .idle         (state == S_IDLE)
);

//--- src/mul_core_top.sv
// Top level chaining decode, microcode sequencer, issue and execute
`timescale 1ns/1ps

module mul_core_top
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  instr_t            instr,
    output logic              busy,
    input  logic [REG_AW-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data,
    output flags_t            flags
);

    logic              start_mul;
    mul_req_t          req;
    logic [REG_AW-1:0] rs2_addr;
    logic [DATA_W-1:0] rs2_data;
    logic              dec_valid;
    instr_t            dec_instr;
    logic              uop_active;
    instr_t            uop;
    logic              flags_restore;
    flags_t            saved_flags;
    logic              iss_valid;
    instr_t            iss_instr;

    mul_decode mul_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .busy       (busy),
        .rs2_data   (rs2_data),
        .rs2_addr   (rs2_addr),
        .start_mul  (start_mul),
        .req        (req),
        .dec_valid  (dec_valid),
        .dec_instr  (dec_instr)
    );

    ucode_sequencer ucode_sequencer_inst (
        .clk          (clk),
        .rst          (rst),
        .start_mul    (start_mul),
        .req          (req),
        .flags        (flags),
        .uop_active   (uop_active),
        .uop          (uop),
        .busy         (busy),
        .flags_restore(flags_restore),
        .saved_flags  (saved_flags)
    );

    issue_stage issue_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_instr (dec_instr),
        .uop_active(uop_active),
        .uop       (uop),
        .iss_valid (iss_valid),
        .iss_instr (iss_instr)
    );

    exec_stage exec_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .iss_valid    (iss_valid),
        .iss_instr    (iss_instr),
        .flags_restore(flags_restore),
        .saved_flags  (saved_flags),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rs2_addr     (rs2_addr),
        .rs2_data     (rs2_data),
        .flags        (flags)
    );

endmodule

//--- src/exec_stage.sv
// Execute stage with register file, ALU, NZCV flags and debug read port
`timescale 1ns/1ps

module exec_stage
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              iss_valid,
    input  instr_t            iss_instr,
    input  logic              flags_restore,
    input  flags_t            saved_flags,
    input  logic [REG_AW-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data,
    input  logic [REG_AW-1:0] rs2_addr,
    output logic [DATA_W-1:0] rs2_data,
    output flags_t            flags
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [DATA_W-1:0] a, b, imm_sext;     // Operands
    logic [DATA_W:0]   sum, diff;          // Extra bit holds the carry
    logic [DATA_W-1:0] result;
    logic              wr_en;
    logic              set_flags;
    flags_t            flags_nxt;

    assign a        = regs[iss_instr.rs1];
    assign b        = regs[iss_instr.op.r.rs2];
    assign imm_sext = {{(DATA_W-IMM_W){iss_instr.op.i.imm16[IMM_W-1]}}, iss_instr.op.i.imm16};
    assign sum      = {1'b0, a} + {1'b0, b};
    assign diff     = {1'b0, a} + {1'b0, ~b} + 1'b1;   // Carry set means no borrow

    // Opcode decode and ALU
    always_comb begin
        wr_en     = 1'b0;
        set_flags = 1'b0;
        result    = '0;
        flags_nxt = flags;
        if (iss_valid) begin
            case (iss_instr.opcode)
                MOV_OP:  begin result = imm_sext;          wr_en = 1'b1; end
                ADD_OP:  begin result = sum[DATA_W-1:0];   wr_en = 1'b1; end
                SUB_OP:  begin result = diff[DATA_W-1:0];  wr_en = 1'b1; end
                SUBI_OP: begin result = a - imm_sext;      wr_en = 1'b1; end
                NOT_OP:  begin result = ~a;                wr_en = 1'b1; end
                ADDS_OP: begin
                    result      = sum[DATA_W-1:0];
                    wr_en       = 1'b1;
                    set_flags   = 1'b1;
                    flags_nxt.c = sum[DATA_W];
                    // Same-sign operands, result sign flipped
                    flags_nxt.v = (a[DATA_W-1] == b[DATA_W-1]) &&
                                  (result[DATA_W-1] != a[DATA_W-1]);
                end
                SUBS_OP: begin
                    result      = diff[DATA_W-1:0];
                    wr_en       = 1'b1;
                    set_flags   = 1'b1;
                    flags_nxt.c = diff[DATA_W];
                    flags_nxt.v = (a[DATA_W-1] != b[DATA_W-1]) &&
                                  (result[DATA_W-1] != a[DATA_W-1]);
                end
                default: ;  // Unknown opcodes write nothing
            endcase
            if (set_flags) begin
                flags_nxt.n = result[DATA_W-1];
                flags_nxt.z = (result == '0);
            end
        end
    end

    // Register file and flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (wr_en) begin
                regs[iss_instr.rd] <= result;
            end
            if (flags_restore) begin
                flags <= saved_flags;   // Wins over a last ADDS/SUBS of the sequence
            end else if (set_flags) begin
                flags <= flags_nxt;
            end
        end
    end

    assign rd_data  = regs[rd_addr];     // Debug port
    assign rs2_data = regs[rs2_addr];    // Multiplier read for decode

endmodule

//--- src/issue_stage.sv
// Issue register, picks decoded or microcode instruction and drops NOPs
`timescale 1ns/1ps

module issue_stage
    import ucode_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   dec_valid,
    input  instr_t dec_instr,
    input  logic   uop_active,
    input  instr_t uop,
    output logic   iss_valid,
    output instr_t iss_instr
);

    logic   sel_valid;
    instr_t sel_instr;

    // Sequencer owns the slot while active
    always_comb begin
        if (uop_active) begin
            sel_instr = uop;
            sel_valid = 1'b1;
        end else begin
            sel_instr = dec_instr;
            sel_valid = dec_valid;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= sel_valid && (sel_instr.opcode != NOP_OP);  // NOPs never reach exec
        end
    end

    always_ff @(posedge clk) begin
        iss_instr <= sel_instr;
    end

endmodule

//--- src/ucode_sequencer.sv
// Microcode sequencer, expands a MUL into MOV/ADD/fix-up micro-instructions
`timescale 1ns/1ps

module ucode_sequencer
    import ucode_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start_mul,
    input  mul_req_t req,
    input  flags_t   flags,
    output logic     uop_active,
    output instr_t   uop,
    output logic     busy,
    output logic     flags_restore,
    output flags_t   saved_flags
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,    // Zero multiplier, one SUBS
        S_MOV,      // Clear Rd before accumulating
        S_ADD,      // One add per unit of magnitude
        S_FIX,      // SUBI #1 then NOT, negates the sum
        S_HALT      // Hand slot back, restore flags
    } state_t;

    state_t            state, state_nxt;
    logic [CNT_W-1:0]  cnt;             // Adds still to issue
    logic [CNT_W-1:0]  mag;             // Magnitude of the incoming multiplier
    logic              signed_kind;     // MULSI or MULSR
    logic              neg_mult;        // Signed kind with negative multiplier
    logic [REG_AW-1:0] rd_q, rs_q;      // Latched request registers
    logic              signed_q;
    logic              neg_q;
    logic              fix_step;        // 0 issues SUBI, 1 issues NOT

    // Multiplier magnitude from kind and sign
    always_comb begin
        signed_kind = 1'b0;
        neg_mult    = 1'b0;
        mag         = '0;
        case (req.kind)
            MULI: mag = CNT_W'(req.imm);          // Raw value, zero extended
            MULR: mag = CNT_W'(req.reg_mult);
            MULSI: begin
                signed_kind = 1'b1;
                neg_mult    = req.imm[IMM_W-1];
                mag         = {{(CNT_W-IMM_W){req.imm[IMM_W-1]}}, req.imm};
                if (neg_mult) begin
                    mag = -mag;                 // Two's-complement magnitude
                end
            end
            MULSR: begin
                signed_kind = 1'b1;
                neg_mult    = req.reg_mult[DATA_W-1];
                mag         = CNT_W'(req.reg_mult);
                if (neg_mult) begin
                    mag = -mag;
                end
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            cnt      <= '0;
            fix_step <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                S_IDLE:  if (start_mul) cnt <= mag;
                S_ADD:   cnt <= cnt - 1'b1;
                S_FIX:   fix_step <= ~fix_step;    // Back to 0 after NOT
                default: ;
            endcase
        end
    end

    // Request held for the whole sequence
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_mul) begin
            rd_q     <= req.rd;
            rs_q     <= req.rs;
            signed_q <= signed_kind;
            neg_q    <= neg_mult;
        end
        // Saved in the first active cycle, earlier writers have landed by then
        if (state == S_CLEAR || state == S_MOV) begin
            saved_flags <= flags;
        end
    end

    // Next state and micro-instruction
    always_comb begin
        state_nxt  = state;
        uop_active = 1'b0;
        uop        = '0;
        uop.opcode = NOP_OP;    // Idle slot carries a NOP
        case (state)
            S_IDLE: begin
                if (start_mul) begin
                    state_nxt = (mag == '0) ? S_CLEAR : S_MOV;
                end
            end
            S_CLEAR: begin
                uop_active     = 1'b1;
                uop.opcode     = SUBS_OP;       // Rd - Rd
                uop.rd         = rd_q;
                uop.rs1        = rd_q;
                uop.op.r.rs2   = rd_q;
                state_nxt      = S_HALT;
            end
            S_MOV: begin
                uop_active = 1'b1;
                uop.opcode = MOV_OP;            // imm16 left at zero
                uop.rd     = rd_q;
                state_nxt  = S_ADD;
            end
            S_ADD: begin
                uop_active   = 1'b1;
                uop.opcode   = signed_q ? ADDS_OP : ADD_OP;
                uop.rd       = rd_q;
                uop.rs1      = rd_q;
                uop.op.r.rs2 = rs_q;
                if (cnt == CNT_W'(1)) begin     // Last add
                    state_nxt = neg_q ? S_FIX : S_HALT;
                end
            end
            S_FIX: begin
                uop_active = 1'b1;
                uop.rd     = rd_q;
                uop.rs1    = rd_q;
                if (!fix_step) begin
                    uop.opcode      = SUBI_OP;
                    uop.op.i.imm16  = IMM_W'(1);
                end else begin
                    uop.opcode = NOT_OP;        // ~(x - 1) is -x
                    state_nxt  = S_HALT;
                end
            end
            S_HALT:  state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    assign busy          = start_mul || (state != S_IDLE);  // Covers the decode hold cycle
    assign flags_restore = (state == S_HALT);

endmodule

//--- src/mul_decode.sv
// Decode stage, registers accepted instructions and steers MULs to the sequencer
`timescale 1ns/1ps

module mul_decode
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  instr_t            instr,
    input  logic              busy,
    input  logic [DATA_W-1:0] rs2_data,
    output logic [REG_AW-1:0] rs2_addr,
    output logic              start_mul,
    output mul_req_t          req,
    output logic              dec_valid,
    output instr_t            dec_instr
);

    logic   accept;     // Strobe taken this cycle
    logic   is_mul_in;  // Incoming opcode belongs to the MUL family
    instr_t instr_q;    // Last accepted instruction

    assign accept    = instr_valid && !busy;   // Strobes under busy are dropped
    assign is_mul_in = (instr.opcode[6:2] == MUL_BASE_OP[6:2]);

    // Control strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_mul <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            start_mul <= accept && is_mul_in;
            dec_valid <= accept && !is_mul_in;
        end
    end

    // Instruction payload
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    assign dec_instr = instr_q;
    assign rs2_addr  = instr_q.op.r.rs2;    // Multiplier register for MULR/MULSR

    // Request fields, reg_mult read from exec in the start_mul cycle
    assign req.kind     = mul_kind_t'(instr_q.opcode[1:0]);
    assign req.rd       = instr_q.rd;
    assign req.rs       = instr_q.rs1;
    assign req.imm      = instr_q.op.i.imm16;
    assign req.reg_mult = rs2_data;

endmodule

//--- src/ucode_pkg.sv
// Shared types, opcodes and sizes for the microcoded multiply pipeline
package ucode_pkg;

    // Sizes
    localparam int NUM_REGS = 16;                 // Architectural registers
    localparam int DATA_W   = 32;                 // Register and ALU width
    localparam int CNT_W    = 32;                 // Magnitude counter in the sequencer
    localparam int REG_AW   = $clog2(NUM_REGS);   // Register index width
    localparam int IMM_W    = 16;                 // Immediate field width

    // ALU opcodes, only the S forms touch NZCV
    localparam logic [6:0] MOV_OP  = 7'b0000000;  // Rd = sext(imm16)
    localparam logic [6:0] ADD_OP  = 7'b0110001;
    localparam logic [6:0] ADDS_OP = 7'b0111001;
    localparam logic [6:0] SUB_OP  = 7'b0110010;
    localparam logic [6:0] SUBS_OP = 7'b0111010;
    localparam logic [6:0] SUBI_OP = 7'b0010010;  // Rd = Rs1 - sext(imm16)
    localparam logic [6:0] NOT_OP  = 7'b0110110;  // Rd = ~Rs1
    localparam logic [6:0] NOP_OP  = 7'b1100100;  // Prefix 11001, rest zero

    // MUL family, low two opcode bits carry the kind
    localparam logic [6:0] MUL_BASE_OP = 7'b1010000;

    typedef enum logic [1:0] {
        MULI  = 2'd0,   // Unsigned, immediate multiplier
        MULR  = 2'd1,   // Unsigned, register multiplier
        MULSI = 2'd2,   // Signed, immediate multiplier
        MULSR = 2'd3    // Signed, register multiplier
    } mul_kind_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // Low 17 bits seen as rs2 form or immediate form
    typedef struct packed {
        logic [REG_AW-1:0] rs2;
        logic [12:0]       rsvd;
    } op_reg_t;

    typedef struct packed {
        logic             rsvd;
        logic [IMM_W-1:0] imm16;
    } op_imm_t;

    typedef union packed {
        op_reg_t r;
        op_imm_t i;
    } operand_t;

    typedef struct packed {
        logic [6:0]        opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        operand_t          op;      // rs2 overlaps the top of imm16
    } instr_t;

    // Decode to sequencer request
    typedef struct packed {
        mul_kind_t         kind;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs;          // Multiplicand register
        logic [IMM_W-1:0]  imm;         // Immediate multiplier
        logic [DATA_W-1:0] reg_mult;    // Value of the multiplier register
    } mul_req_t;

endpackage
